// File: common/float_op_if.sv
// Start/ready operand interface between the dot-product controller and one scalar float unit
`timescale 1ns/1ns

interface float_op_if;

  // Strobes, one cycle each
  logic start;
  logic ready;

  // Operands held by requester from start until ready
  vector_pkg::float_t data_a;
  vector_pkg::float_t data_b;

  // Valid only in the ready cycle
  vector_pkg::float_t result;

  modport requester (
    output start,
    output data_a,
    output data_b,
    input  ready,
    input  result
  );

  modport unit (
    input  start,
    input  data_a,
    input  data_b,
    output ready,
    output result
  );

endinterface

// File: common/vector_pkg.sv
// Shared binary32 float types and format constants, referenced by scoped name from RTL and testbench
package vector_pkg;

  ////////////////////////////////////////
  // Format widths
  ////////////////////////////////////////

  // Whole word, biased exponent, significand with hidden bit
  localparam int FLOAT_WIDTH = 32;
  localparam int EXP_WIDTH   = 8;
  localparam int MANT_WIDTH  = 24;

  // Signed exponent with headroom for sums and underflow checks
  localparam int SEXP_WIDTH  = EXP_WIDTH + 2;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [FLOAT_WIDTH-1:0] float_t;
  typedef logic [EXP_WIDTH-1:0] exp_t;
  typedef logic [MANT_WIDTH-1:0] mant_t;

  // Stored fraction, hidden bit dropped
  typedef logic [MANT_WIDTH-2:0] frac_t;

  // Intermediate exponent, may go negative before flush
  typedef logic signed [SEXP_WIDTH-1:0] sexp_t;

  ////////////////////////////////////////
  // Constants
  ////////////////////////////////////////

  localparam int FLOAT_BIAS = 127;

  // Positive zero, also the value of an exact cancellation
  localparam float_t FLOAT_ZERO = 32'h0000_0000;

endpackage

// File: dv/vector_tb.sv
// Testbench for the dot-product top level; replays dv/vector_tests.txt with random strobe pacing
`timescale 1ns/1ns

module vector_tb;

  localparam int LENGTH_SIZE = 8;
  localparam int TIMEOUT_CYCLES = 200;
  localparam logic [31:0] SEED = 32'h2034cb2f;

  // Sent first and then overwritten in repeat mode
  localparam vector_pkg::float_t STALE_WORD = 32'h42c80000;

  // Strobe order modes, last column of a test header
  localparam int MODE_B_FIRST = 1;
  localparam int MODE_SAME = 2;
  localparam int MODE_REPEAT = 3;

  logic                   CLK;
  logic                   RST;
  logic                   start;
  logic [LENGTH_SIZE-1:0] length_in;
  vector_pkg::float_t     data_a_in;
  logic                   data_a_in_enable;
  vector_pkg::float_t     data_b_in;
  logic                   data_b_in_enable;
  vector_pkg::float_t     data_out;
  logic                   data_out_enable;
  logic                   ready;

  // Test currently loaded from the file
  logic [8*32-1:0]        test_name;
  int                     test_length;
  int                     test_mode;
  vector_pkg::float_t     a_list[$];
  vector_pkg::float_t     b_list[$];
  vector_pkg::float_t     sum_list[$];

  logic [31:0]            rng_state;
  int                     pass_count;
  int                     fail_count;
  int                     run_count;
  logic                   test_ok;
  logic                   aborted;

  vector_top #(
    .LENGTH_SIZE(LENGTH_SIZE)
  ) u_dut (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .length_in        (length_in),
    .data_a_in        (data_a_in),
    .data_a_in_enable (data_a_in_enable),
    .data_b_in        (data_b_in),
    .data_b_in_enable (data_b_in_enable),
    .data_out         (data_out),
    .data_out_enable  (data_out_enable),
    .ready            (ready)
  );

  // 100 ns period
  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] value);
    logic [31:0] x;
    x = value;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic pick_random(input int range, output int value);
    rng_state = xorshift32(rng_state);
    value = int'(rng_state % range);
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) @(negedge CLK);
  endtask

  // Each strobe lasts one cycle, from one falling edge to the next
  task automatic strobe_a(input vector_pkg::float_t value);
    data_a_in = value;
    data_a_in_enable = 1'b1;
    @(negedge CLK);
    data_a_in_enable = 1'b0;
  endtask

  task automatic strobe_b(input vector_pkg::float_t value);
    data_b_in = value;
    data_b_in_enable = 1'b1;
    @(negedge CLK);
    data_b_in_enable = 1'b0;
  endtask

  task automatic strobe_both(input vector_pkg::float_t a, input vector_pkg::float_t b);
    data_a_in = a;
    data_b_in = b;
    data_a_in_enable = 1'b1;
    data_b_in_enable = 1'b1;
    @(negedge CLK);
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
  endtask

  // Idle gap, then the two sides in the order the mode asks for
  task automatic send_pair(input vector_pkg::float_t a, input vector_pkg::float_t b);
    int idle;
    int order;
    int gap;
    pick_random(4, idle);
    idle_cycles(idle);
    pick_random(3, order);
    pick_random(4, gap);
    if (test_mode == MODE_B_FIRST) order = 1;
    else if (test_mode == MODE_SAME) order = 2;
    else if (test_mode == MODE_REPEAT) order = 3;
    case (order)
      0: begin
        strobe_a(a);
        idle_cycles(gap);
        strobe_b(b);
      end
      1: begin
        strobe_b(b);
        idle_cycles(gap);
        strobe_a(a);
      end
      2: strobe_both(a, b);
      default: begin
        // Stale a first, the later strobe must win
        strobe_a(STALE_WORD);
        idle_cycles(gap);
        strobe_a(a);
        strobe_b(b);
      end
    endcase
  endtask

  // Returns at the falling edge where the strobe is seen
  task automatic wait_for_output(output logic seen);
    int cycles;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      if (data_out_enable) seen = 1'b1;
      else begin
        @(negedge CLK);
        cycles++;
      end
    end
  endtask

  task automatic wait_for_ready(output logic seen, output logic enable_seen);
    int cycles;
    seen = 1'b0;
    enable_seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      if (data_out_enable) enable_seen = 1'b1;
      if (ready) seen = 1'b1;
      else begin
        @(negedge CLK);
        cycles++;
      end
    end
  endtask

  task automatic report_mismatch(input string what, input vector_pkg::float_t expected,
                                 input vector_pkg::float_t actual);
    $display("Fail %0s %0s: expected %h, actual %h", test_name, what, expected, actual);
    test_ok = 1'b0;
  endtask

  task automatic close_test();
    if (test_ok) pass_count++;
    else fail_count++;
    $display("%0s: %0s", test_name, test_ok ? "ok" : "errors");
  endtask

  // Idle DUT right after reset
  task automatic check_after_reset();
    test_ok = 1'b1;
    test_name = "after_reset";
    repeat (5) begin
      if (ready !== 1'b0 || data_out_enable !== 1'b0) begin
        $display("A strobe is high after reset with no start given");
        test_ok = 1'b0;
      end
      if (data_out !== vector_pkg::FLOAT_ZERO) begin
        report_mismatch("data_out", vector_pkg::FLOAT_ZERO, data_out);
      end
      @(negedge CLK);
    end
    close_test();
  endtask

  ////////////////////////////////////////
  // One vector from the tests file
  ////////////////////////////////////////

  task automatic run_test(input vector_pkg::float_t final_sum);
    logic seen;
    logic enable_seen;
    int   idle;
    test_ok = 1'b1;
    run_count++;
    if (a_list.size() != test_length) begin
      $display("Tests file lists %0d elements for %0s, its header says %0d",
               a_list.size(), test_name, test_length);
      test_ok = 1'b0;
    end else begin
      pick_random(4, idle);
      idle_cycles(idle);
      start = 1'b1;
      length_in = LENGTH_SIZE'(test_length);
      @(negedge CLK);
      start = 1'b0;
      if (test_length == 0) begin
        wait_for_ready(seen, enable_seen);
        if (!seen) begin
          $display("Timeout: ready never came for %0s", test_name);
          test_ok = 1'b0;
          aborted = 1'b1;
        end else begin
          if (enable_seen) begin
            $display("data_out_enable pulsed for the empty vector %0s", test_name);
            test_ok = 1'b0;
          end
          if (data_out !== final_sum) report_mismatch("final", final_sum, data_out);
        end
      end else begin
        for (int i = 0; i < test_length && !aborted; i++) begin
          send_pair(a_list[i], b_list[i]);
          wait_for_output(seen);
          if (!seen) begin
            $display("Timeout: data_out_enable never came for %0s element %0d", test_name, i);
            test_ok = 1'b0;
            aborted = 1'b1;
          end else begin
            if (data_out !== sum_list[i]) begin
              report_mismatch($sformatf("element %0d", i), sum_list[i], data_out);
            end
            // Ready only with the last partial sum
            if (ready !== (i == test_length - 1)) begin
              $display("ready %0s at element %0d of %0s", ready ? "early" : "missing",
                       i, test_name);
              test_ok = 1'b0;
            end
            if (i == test_length - 1 && data_out !== final_sum) begin
              report_mismatch("final", final_sum, data_out);
            end
          end
        end
      end
    end
    close_test();
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int                 fd;
    int                 fields;
    int                 status;
    logic [8*160-1:0]   line_buf;
    logic [8*8-1:0]     keyword;
    vector_pkg::float_t word_a;
    vector_pkg::float_t word_b;
    vector_pkg::float_t word_sum;
    RST = 1'b1;
    start = 1'b0;
    length_in = '0;
    data_a_in = '0;
    data_a_in_enable = 1'b0;
    data_b_in = '0;
    data_b_in_enable = 1'b0;
    rng_state = SEED;
    pass_count = 0;
    fail_count = 0;
    run_count = 0;
    test_length = 0;
    test_mode = 0;
    aborted = 1'b0;
    idle_cycles(10);
    RST = 1'b0;
    check_after_reset();
    fd = $fopen("dv/vector_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open dv/vector_tests.txt");
      fail_count++;
    end else begin
      while (!$feof(fd) && !aborted) begin
        line_buf = '0;
        keyword = '0;
        status = $fgets(line_buf, fd);
        fields = $sscanf(line_buf, "%s", keyword);
        // Comment and blank lines match no keyword
        if (status != 0 && fields == 1) begin
          if (keyword == "test") begin
            test_name = '0;
            fields = $sscanf(line_buf, "%s %s %d %d", keyword, test_name, test_length, test_mode);
            if (fields != 4) begin
              $display("Malformed test header in the tests file");
              fail_count++;
            end
            a_list.delete();
            b_list.delete();
            sum_list.delete();
          end else if (keyword == "elem") begin
            fields = $sscanf(line_buf, "%s %h %h %h", keyword, word_a, word_b, word_sum);
            if (fields != 4) begin
              $display("Malformed element line in %0s", test_name);
              fail_count++;
            end else begin
              a_list.push_back(word_a);
              b_list.push_back(word_b);
              sum_list.push_back(word_sum);
            end
          end else if (keyword == "final") begin
            fields = $sscanf(line_buf, "%s %h", keyword, word_sum);
            run_test(word_sum);
          end
        end
      end
      $fclose(fd);
      if (run_count == 0) begin
        $display("No test was read from the tests file");
        fail_count++;
      end
    end
    $display("Summary: %0d passed, %0d with errors", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: dv/vector_tests.txt
# test <name> <length> <mode: 0 random, 1 b first, 2 same cycle, 3 a repeated>
# elem <a> <b> <partial sum>, final <result>; all values binary32 in hex
test exact_ints 4 0
elem 3f800000 40000000 40000000
elem 40400000 40800000 41600000
elem 3f000000 41000000 41900000
elem 40000000 3e800000 41940000
final 41940000
test powers_b_first 3 1
elem 40800000 40800000 41800000
elem 41000000 3f000000 41a00000
elem 3e800000 3e800000 41a08000
final 41a08000
test cancel_same_cycle 3 2
elem 40400000 40000000 40c00000
elem bf800000 40800000 40000000
elem bf800000 40000000 00000000
final 00000000
test truncation 3 0
elem 3fffffff 3f800000 3fffffff
elem 33c00000 3f800000 3fffffff
elem bf800000 3f800000 3f7ffffe
final 3f7ffffe
test repeat_a 2 3
elem 40000000 40400000 40c00000
elem 40800000 3fc00000 41400000
final 41400000
test empty 0 0
final 00000000
test underflow 3 0
elem 40a00000 3f800000 40a00000
elem 1c800000 1c800000 40a00000
elem bf800000 40000000 40400000
final 40400000
test exact_ints_same_cycle 4 2
elem 3f800000 40000000 40000000
elem 40400000 40800000 41600000
elem 3f000000 41000000 41900000
elem 40000000 3e800000 41940000
final 41940000

// File: flist.f
common/vector_pkg.sv
common/float_op_if.sv
float/float_multiplier.sv
float/float_adder.sv
hdl/vector_dot_product.sv
hdl/vector_top.sv
dv/vector_tb.sv

// File: float/float_adder.sv
// Three-stage truncating binary32 adder; ready pulses three cycles after each start
`timescale 1ns/1ns

module float_adder (
  input logic CLK,
  input logic RST,
  float_op_if.unit op
);

  // Significand sum with carry bit
  typedef logic [vector_pkg::MANT_WIDTH:0] sum_t;

  ////////////////////////////////////////
  // Stage 1 swaps and aligns
  ////////////////////////////////////////

  logic                a_larger;
  vector_pkg::float_t  big_op;
  vector_pkg::float_t  small_op;
  vector_pkg::exp_t    big_exp;
  vector_pkg::exp_t    small_exp;
  vector_pkg::exp_t    exp_diff;
  vector_pkg::mant_t   big_mant;
  vector_pkg::mant_t   small_mant;

  logic                s1_valid;
  logic                s1_sign_q;
  logic                s1_sub_q;
  vector_pkg::exp_t    s1_exp_q;
  vector_pkg::mant_t   s1_big_q;
  vector_pkg::mant_t   s1_small_q;

  ////////////////////////////////////////
  // Stage 2 adds or subtracts
  ////////////////////////////////////////

  sum_t                s2_sum_d;

  logic                s2_valid;
  logic                s2_sign_q;
  vector_pkg::exp_t    s2_exp_q;
  sum_t                s2_sum_q;

  ////////////////////////////////////////
  // Stage 3 normalizes
  ////////////////////////////////////////

  logic [4:0]          lz;
  vector_pkg::mant_t   norm;
  vector_pkg::sexp_t   s3_exp;
  vector_pkg::frac_t   s3_frac;
  vector_pkg::float_t  s3_result;

  // Leading zeros of a 24-bit significand
  function automatic logic [4:0] lead_zeros(input vector_pkg::mant_t value);
    logic [4:0] count;
    logic       found;
    count = 5'd0;
    found = 1'b0;
    for (int i = vector_pkg::MANT_WIDTH - 1; i >= 0; i--) begin
      if (!found) begin
        if (value[i]) begin
          found = 1'b1;
        end else begin
          count = count + 5'd1;
        end
      end
    end
    return count;
  endfunction

  // Magnitude compare on the raw bits works for normals
  always_comb begin
    a_larger   = op.data_a[30:0] >= op.data_b[30:0];
    big_op     = a_larger ? op.data_a : op.data_b;
    small_op   = a_larger ? op.data_b : op.data_a;
    big_exp    = big_op[30:23];
    small_exp  = small_op[30:23];
    // Zero exponent reads as zero whatever the fraction
    big_mant   = (big_exp == '0) ? '0 : {1'b1, big_op[22:0]};
    small_mant = (small_exp == '0) ? '0 : {1'b1, small_op[22:0]};
    exp_diff   = big_exp - small_exp;
  end

  // Larger magnitude first so the difference never goes negative
  always_comb begin
    if (s1_sub_q) begin
      s2_sum_d = {1'b0, s1_big_q} - {1'b0, s1_small_q};
    end else begin
      s2_sum_d = {1'b0, s1_big_q} + {1'b0, s1_small_q};
    end
  end

  always_comb begin
    lz      = lead_zeros(s2_sum_q[23:0]);
    norm    = s2_sum_q[23:0] << lz;
    s3_frac = norm[22:0];
    s3_exp  = vector_pkg::sexp_t'({2'b00, s2_exp_q}) - vector_pkg::sexp_t'({5'b0, lz});
    // On carry out shift right by one and drop the last bit
    if (s2_sum_q[24]) begin
      s3_frac = s2_sum_q[23:1];
      s3_exp  = vector_pkg::sexp_t'({2'b00, s2_exp_q}) + vector_pkg::sexp_t'(1);
    end
    if (s2_sum_q == '0) begin
      // Exact cancellation
      s3_result = vector_pkg::FLOAT_ZERO;
    end else if (s3_exp <= vector_pkg::sexp_t'(0)) begin
      s3_result = {s2_sign_q, 31'b0};
    end else begin
      s3_result = {s2_sign_q, s3_exp[7:0], s3_frac};
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      op.ready <= 1'b0;
    end else begin
      s1_valid <= op.start;
      s2_valid <= s1_valid;
      op.ready <= s2_valid;
    end
  end

  always_ff @(posedge CLK) begin
    s1_sign_q  <= big_op[31];
    s1_sub_q   <= big_op[31] ^ small_op[31];
    s1_exp_q   <= big_exp;
    s1_big_q   <= big_mant;
    // Bits shifted out are lost
    s1_small_q <= small_mant >> exp_diff;
    s2_sign_q  <= s1_sign_q;
    s2_exp_q   <= s1_exp_q;
    s2_sum_q   <= s2_sum_d;
    op.result  <= s3_result;
  end

endmodule

// File: float/float_multiplier.sv
// Two-stage truncating binary32 multiplier; ready pulses two cycles after each start
`timescale 1ns/1ns

module float_multiplier (
  input logic CLK,
  input logic RST,
  float_op_if.unit op
);

  // Full significand product
  typedef logic [2*vector_pkg::MANT_WIDTH-1:0] prod_t;

  ////////////////////////////////////////
  // Stage 1 signals
  ////////////////////////////////////////

  logic                s1_sign_d;
  logic                s1_zero_d;
  vector_pkg::sexp_t   s1_exp_d;
  vector_pkg::mant_t   mant_a;
  vector_pkg::mant_t   mant_b;
  prod_t               s1_prod_d;

  logic                s1_valid;
  logic                s1_sign_q;
  logic                s1_zero_q;
  vector_pkg::sexp_t   s1_exp_q;
  prod_t               s1_prod_q;

  ////////////////////////////////////////
  // Stage 2 signals
  ////////////////////////////////////////

  vector_pkg::sexp_t   s2_exp;
  vector_pkg::frac_t   s2_frac;
  vector_pkg::float_t  s2_result;

  // Sign, exponent sum less bias, raw significand product
  always_comb begin
    s1_sign_d = op.data_a[31] ^ op.data_b[31];
    // Zero exponent covers zero and flushed subnormal inputs
    s1_zero_d = (op.data_a[30:23] == '0) || (op.data_b[30:23] == '0);
    s1_exp_d  = vector_pkg::sexp_t'({2'b00, op.data_a[30:23]})
              + vector_pkg::sexp_t'({2'b00, op.data_b[30:23]})
              - vector_pkg::sexp_t'(vector_pkg::FLOAT_BIAS);
    mant_a    = {1'b1, op.data_a[22:0]};
    mant_b    = {1'b1, op.data_b[22:0]};
    s1_prod_d = prod_t'(mant_a) * prod_t'(mant_b);
  end

  // Product of two values in [1,2) lies in [1,4)
  // One-bit normalize, low bits simply dropped
  always_comb begin
    if (s1_prod_q[47]) begin
      s2_frac = s1_prod_q[46:24];
      s2_exp  = s1_exp_q + vector_pkg::sexp_t'(1);
    end else begin
      s2_frac = s1_prod_q[45:23];
      s2_exp  = s1_exp_q;
    end
    // Underflow or zero operand gives signed zero
    if (s1_zero_q || (s2_exp <= vector_pkg::sexp_t'(0))) begin
      s2_result = {s1_sign_q, 31'b0};
    end else begin
      s2_result = {s1_sign_q, s2_exp[7:0], s2_frac};
    end
  end

  // Valid bits, one per stage
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
      op.ready <= 1'b0;
    end else begin
      s1_valid <= op.start;
      op.ready <= s1_valid;
    end
  end

  // Datapath registers
  always_ff @(posedge CLK) begin
    s1_sign_q <= s1_sign_d;
    s1_zero_q <= s1_zero_d;
    s1_exp_q  <= s1_exp_d;
    s1_prod_q <= s1_prod_d;
    op.result <= s2_result;
  end

endmodule

// File: hdl/vector_dot_product.sv
// Dot-product controller: collects element pairs, runs multiply then accumulate, reports sums
`timescale 1ns/1ns

module vector_dot_product #(
  parameter int LENGTH_SIZE = 8
) (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   start,
  input  logic [LENGTH_SIZE-1:0] length_in,
  input  vector_pkg::float_t     data_a_in,
  input  logic                   data_a_in_enable,
  input  vector_pkg::float_t     data_b_in,
  input  logic                   data_b_in_enable,
  output vector_pkg::float_t     data_out,
  output logic                   data_out_enable,
  output logic                   ready,
  float_op_if.requester          mul,
  float_op_if.requester          add
);

  typedef enum logic [2:0] {
    st_starter,
    st_input,
    st_mul_wait,
    st_update,
    st_add_wait
  } state_t;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  state_t                 state;
  logic [LENGTH_SIZE-1:0] count_q;
  logic                   last_q;

  // Element pair and its held flags
  vector_pkg::float_t     a_q;
  vector_pkg::float_t     b_q;
  logic                   a_held;
  logic                   b_held;
  logic                   pair_done;

  // Product in flight and running sum
  vector_pkg::float_t     prod_q;
  vector_pkg::float_t     sum_q;

  // Both sides present, counting this cycle's strobes
  assign pair_done = (a_held || data_a_in_enable) && (b_held || data_b_in_enable);

  // Operands stay put while the units work
  assign mul.data_a = a_q;
  assign mul.data_b = b_q;
  assign add.data_a = prod_q;
  assign add.data_b = sum_q;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= st_starter;
      count_q         <= '0;
      last_q          <= 1'b0;
      a_held          <= 1'b0;
      b_held          <= 1'b0;
      mul.start       <= 1'b0;
      add.start       <= 1'b0;
      data_out        <= vector_pkg::FLOAT_ZERO;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
    end else begin
      // Strobes default low
      mul.start       <= 1'b0;
      add.start       <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
      case (state)
        st_starter: begin
          if (start) begin
            if (length_in == '0) begin
              // Empty vector, result is +0 at once
              ready    <= 1'b1;
              data_out <= vector_pkg::FLOAT_ZERO;
            end else begin
              count_q <= length_in;
              a_held  <= 1'b0;
              b_held  <= 1'b0;
              state   <= st_input;
            end
          end
        end
        st_input: begin
          if (data_a_in_enable) begin
            a_held <= 1'b1;
          end
          if (data_b_in_enable) begin
            b_held <= 1'b1;
          end
          // Pair complete, multiplier starts next cycle
          if (pair_done) begin
            mul.start <= 1'b1;
            a_held    <= 1'b0;
            b_held    <= 1'b0;
            state     <= st_mul_wait;
          end
        end
        st_mul_wait: begin
          if (mul.ready) begin
            add.start <= 1'b1;
            state     <= st_update;
          end
        end
        st_update: begin
          // Counted while the adder runs
          count_q <= count_q - 1'b1;
          last_q  <= (count_q == LENGTH_SIZE'(1));
          state   <= st_add_wait;
        end
        st_add_wait: begin
          if (add.ready) begin
            data_out        <= add.result;
            data_out_enable <= 1'b1;
            ready           <= last_q;
            state           <= last_q ? st_starter : st_input;
          end
        end
        default: begin
          state <= st_starter;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Operand and sum registers
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Latest strobe of a side wins
    if ((state == st_input) && data_a_in_enable) begin
      a_q <= data_a_in;
    end
    if ((state == st_input) && data_b_in_enable) begin
      b_q <= data_b_in;
    end
    if ((state == st_mul_wait) && mul.ready) begin
      prod_q <= mul.result;
    end
    // Fresh sum per vector, then adder output feeds back
    if ((state == st_starter) && start) begin
      sum_q <= vector_pkg::FLOAT_ZERO;
    end else if ((state == st_add_wait) && add.ready) begin
      sum_q <= add.result;
    end
  end

endmodule

// File: hdl/vector_top.sv
// Top level of the dot-product block: plain ports, controller plus scalar multiplier and adder
`timescale 1ns/1ns

module vector_top #(
  parameter int LENGTH_SIZE = 8
) (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   start,
  input  logic [LENGTH_SIZE-1:0] length_in,
  input  vector_pkg::float_t     data_a_in,
  input  logic                   data_a_in_enable,
  input  vector_pkg::float_t     data_b_in,
  input  logic                   data_b_in_enable,
  output vector_pkg::float_t     data_out,
  output logic                   data_out_enable,
  output logic                   ready
);

  ////////////////////////////////////////
  // Unit links
  ////////////////////////////////////////

  float_op_if mul_if ();
  float_op_if add_if ();

  // Element sequencing and accumulation
  vector_dot_product #(
    .LENGTH_SIZE(LENGTH_SIZE)
  ) u_dot_product (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .length_in        (length_in),
    .data_a_in        (data_a_in),
    .data_a_in_enable (data_a_in_enable),
    .data_b_in        (data_b_in),
    .data_b_in_enable (data_b_in_enable),
    .data_out         (data_out),
    .data_out_enable  (data_out_enable),
    .ready            (ready),
    .mul              (mul_if.requester),
    .add              (add_if.requester)
  );

  // Products, two cycles
  float_multiplier u_multiplier (
    .CLK (CLK),
    .RST (RST),
    .op  (mul_if.unit)
  );

  // Accumulation, three cycles
  float_adder u_adder (
    .CLK (CLK),
    .RST (RST),
    .op  (add_if.unit)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the dot-product testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module vector_tb \
  -f flist.f --Mdir obj_dir -o vector_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/vector_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
  exit 0
fi
exit 1
